// File: vlog.f
hdl/bcrypt_pkg.sv
hdl/core_mem_if.sv
hdl/bus_addr_decoder.sv
hdl/core_ram_bank.sv
hdl/core_control.sv
hdl/read_return.sv
hdl/bcrypt_user_logic.sv
testbench/tb_bcrypt_user_logic.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, and judge the result from the log
cd "$(dirname "$0")" || exit 1

verilator --binary --assert --top-module tb_bcrypt_user_logic -f vlog.f \
	&& ./obj_dir/Vtb_bcrypt_user_logic | tee sim.log \
	|| { echo "Build or simulation run failed"; exit 1; }

grep -q "Some tests failed" sim.log && { echo "Simulation FAILED"; exit 1; }
grep -q "All tests passed" sim.log || { echo "Simulation did not complete"; exit 1; }
echo "Simulation passed"

// File: testbench/tb_bcrypt_user_logic.sv
// Testbench for the bcrypt accelerator bus-side logic
// Plays the bus master and the cores, checks RAM contents, ack timing and the handshake

module tb_bcrypt_user_logic;
	import bcrypt_pkg::*;

	localparam int NUM_CORES = 4;
	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 4;
	localparam int WORDS_PER_CORE = 6;	// Random words written per core and region
	localparam int ACK_LIMIT = 8;
	localparam int NUM_OPS = 4 * NUM_CORES * WORDS_PER_CORE + 32;
	localparam int TEST_CYCLES = NUM_OPS * 4 + NUM_CORES * 8 + RESET_CYCLES;
	localparam int WATCHDOG_TIME = 2 * TEST_CYCLES * CLK_PERIOD;

	logic Bus2IP_Clk;
	logic arst_n;
	logic [BUS_AW-1:0] bus2ip_addr;
	region_t bus2ip_cs;
	bus_word_t bus2ip_data;
	logic [BUS_DW/8-1:0] bus2ip_be;
	region_t bus2ip_rdce;
	region_t bus2ip_wrce;
	logic [NUM_CORES-1:0] core_done;
	bus_word_t ip2bus_data;
	logic ip2bus_addrack;
	logic ip2bus_rdack;
	logic ip2bus_wrack;
	logic ip2bus_error;
	logic [NUM_CORES-1:0] core_start;
	logic rdce_any;

	int num_checks = 0;
	int num_errors = 0;
	integer seed;
	bus_word_t ref_other [NUM_CORES][2**OTHER_AW];	// Mirror of the written words
	bus_word_t ref_sbox [NUM_CORES][2**SBOX_AW];
	int wr_region [$];
	int wr_core [$];
	int wr_word [$];

	bcrypt_user_logic #(.NUM_CORES(NUM_CORES)) u_bcrypt_user_logic (
		.Bus2IP_Clk (Bus2IP_Clk),
		.arst_n_i (arst_n),
		.bus2ip_addr_i (bus2ip_addr),
		.bus2ip_cs_i (bus2ip_cs),
		.bus2ip_data_i (bus2ip_data),
		.bus2ip_be_i (bus2ip_be),
		.bus2ip_rdce_i (bus2ip_rdce),
		.bus2ip_wrce_i (bus2ip_wrce),
		.core_done_i (core_done),
		.ip2bus_data_o (ip2bus_data),
		.ip2bus_addrack_o (ip2bus_addrack),
		.ip2bus_rdack_o (ip2bus_rdack),
		.ip2bus_wrack_o (ip2bus_wrack),
		.ip2bus_error_o (ip2bus_error),
		.core_start_o (core_start)
	);

	initial begin
		Bus2IP_Clk = 1'b0;
		forever #(CLK_PERIOD / 2) Bus2IP_Clk = ~Bus2IP_Clk;
	end

	initial begin
		#(WATCHDOG_TIME);
		$display("Watchdog expired: the tests did not finish in %0d time units", WATCHDOG_TIME);
		$display("Some tests failed");
		$finish;
	end

	function automatic void flag_error(input string msg);
		num_errors++;
		$display("[FAIL] %0t: %s", $time, msg);
	endfunction

	function automatic void check_word(input string what, input bus_word_t got,
		input bus_word_t expected);
		num_checks++;
		assert (got == expected)
			else flag_error($sformatf("%s: got %h, expected %h", what, got, expected));
	endfunction

	function automatic region_t region_onehot(input int r);
		return region_t'(1 << r);
	endfunction

	function automatic int word_mask(input int r);
		return (r == REG_OTHER) ? (2**OTHER_AW - 1) : (2**SBOX_AW - 1);
	endfunction

	// Core field sits at bit 8 for the other RAM, bit 12 for the S-box RAM
	function automatic logic [BUS_AW-1:0] ram_addr(input int r, input int core, input int word);
		if (r == REG_OTHER) begin
			return (32'(core) << OTHER_CORE_LSB) | (32'(word) << WORD_LSB);
		end
		return (32'(core) << SBOX_CORE_LSB) | (32'(word) << WORD_LSB);
	endfunction

	function automatic logic [BUS_AW-1:0] ctrl_addr(input int word);
		return 32'(word) << WORD_LSB;
	endfunction

	function automatic bus_word_t mirror_word(input int r, input int core, input int word);
		if (r == REG_OTHER) begin
			return ref_other[core][word];
		end
		return ref_sbox[core][word];
	endfunction

	task automatic bus_write(input int r, input logic [BUS_AW-1:0] addr, input bus_word_t data,
		input logic [BUS_DW/8-1:0] be);
		int waited;
		@(posedge Bus2IP_Clk);
		bus2ip_addr <= addr;
		bus2ip_data <= data;
		bus2ip_be <= be;
		bus2ip_cs <= region_onehot(r);
		bus2ip_wrce <= region_onehot(r);
		waited = 0;
		do begin
			@(negedge Bus2IP_Clk);
			waited++;
		end while (!ip2bus_wrack && waited < ACK_LIMIT);
		if (!ip2bus_wrack) begin
			num_errors++;
			$display("Write acknowledge did not arrive within %0d cycles", ACK_LIMIT);
		end
		@(posedge Bus2IP_Clk);	// DUT takes the write at this edge
		bus2ip_cs <= '0;
		bus2ip_wrce <= '0;
		bus2ip_be <= '0;
	endtask

	task automatic bus_read(input int r, input logic [BUS_AW-1:0] addr, output bus_word_t data);
		int waited;
		@(posedge Bus2IP_Clk);
		bus2ip_addr <= addr;
		bus2ip_cs <= region_onehot(r);
		bus2ip_rdce <= region_onehot(r);
		waited = 0;
		do begin
			@(negedge Bus2IP_Clk);
			waited++;
		end while (!ip2bus_rdack && waited < ACK_LIMIT);
		if (!ip2bus_rdack) begin
			num_errors++;
			$display("Read acknowledge did not arrive within %0d cycles", ACK_LIMIT);
		end
		data = ip2bus_data;
		@(posedge Bus2IP_Clk);
		bus2ip_cs <= '0;
		bus2ip_rdce <= '0;
	endtask

	// Core model reporting one finished job
	task automatic pulse_core_done(input int k);
		@(posedge Bus2IP_Clk);
		core_done[k] <= 1'b1;
		@(posedge Bus2IP_Clk);
		core_done[k] <= 1'b0;
	endtask

	// Start rises on the second edge after the run write
	task automatic expect_start_after_run();
		@(negedge Bus2IP_Clk);
		check_word("core starts one edge after the run write", 32'(core_start), '0);
		@(negedge Bus2IP_Clk);
		check_word("core starts after the run write", 32'(core_start), 32'({NUM_CORES{1'b1}}));
	endtask

	assign rdce_any = |bus2ip_rdce;

	a_write_ack: assert property (@(posedge Bus2IP_Clk) disable iff (!arst_n)
		(|bus2ip_wrce) |-> (ip2bus_wrack && ip2bus_addrack))
		else flag_error("WrAck or AddrAck low in a WrCE cycle");

	a_read_ack: assert property (@(posedge Bus2IP_Clk) disable iff (!arst_n)
		$rose(rdce_any) |=> (ip2bus_rdack && ip2bus_addrack))
		else flag_error("RdAck or AddrAck missing one cycle after RdCE rose");

	a_read_ack_once: assert property (@(posedge Bus2IP_Clk) disable iff (!arst_n)
		ip2bus_rdack |=> !ip2bus_rdack)
		else flag_error("RdAck longer than one cycle");

	a_read_ack_cause: assert property (@(posedge Bus2IP_Clk) disable iff (!arst_n)
		ip2bus_rdack |-> $past(rdce_any))
		else flag_error("RdAck without RdCE in the cycle before");

	a_data_gated: assert property (@(posedge Bus2IP_Clk) disable iff (!arst_n)
		!ip2bus_rdack |-> (ip2bus_data == '0))
		else flag_error("read data not zero outside RdAck");

	a_no_error: assert property (@(posedge Bus2IP_Clk) !ip2bus_error)
		else flag_error("error output high");

	initial begin
		bus_word_t got;
		bus_word_t data;
		int word;
		int idx;
		logic [NUM_CORES-1:0] exp_start;
		int waited;
		seed = 76250;
		arst_n = 1'b0;
		bus2ip_addr = '0;
		bus2ip_cs = '0;
		bus2ip_data = '0;
		bus2ip_be = '0;
		bus2ip_rdce = '0;
		bus2ip_wrce = '0;
		core_done = '0;
		repeat (RESET_CYCLES) @(posedge Bus2IP_Clk);
		arst_n <= 1'b1;

		@(negedge Bus2IP_Clk);
		check_word("RdAck after reset", 32'(ip2bus_rdack), '0);
		check_word("WrAck after reset", 32'(ip2bus_wrack), '0);
		check_word("error after reset", 32'(ip2bus_error), '0);
		check_word("core starts after reset", 32'(core_start), '0);
		bus_read(REG_CTRL, ctrl_addr(1), got);
		check_word("status word after reset", got, '0);

		// Loop order is core, then word, then region
		for (int k = 0; k < NUM_CORES; k++) begin
			for (int i = 0; i < WORDS_PER_CORE; i++) begin
				for (int r = REG_OTHER; r <= REG_SBOX; r++) begin
					if (k == 0) begin
						word = $random(seed) & word_mask(r);
					end else begin
						word = wr_word[i * 2 + (r - REG_OTHER)];	// Same addresses as core 0
					end
					data = $random(seed);
					bus_write(r, ram_addr(r, k, word), data, 4'hF);
					if (r == REG_OTHER) ref_other[k][word] = data;
					else ref_sbox[k][word] = data;
					wr_region.push_back(r);
					wr_core.push_back(k);
					wr_word.push_back(word);
				end
			end
		end
		foreach (wr_region[i]) begin
			bus_read(wr_region[i], ram_addr(wr_region[i], wr_core[i], wr_word[i]), got);
			check_word($sformatf("region %0d core %0d word %0d", wr_region[i], wr_core[i],
				wr_word[i]), got, mirror_word(wr_region[i], wr_core[i], wr_word[i]));
		end

		for (int r = REG_OTHER; r <= REG_SBOX; r++) begin
			// Byte lane 0 off leaves the word alone
			idx = WORDS_PER_CORE * 2 + (r - REG_OTHER);
			word = wr_word[idx];
			bus_write(r, ram_addr(r, 1, word), ~mirror_word(r, 1, word), 4'b1110);
			bus_read(r, ram_addr(r, 1, word), got);
			check_word($sformatf("region %0d write without lane 0", r), got,
				mirror_word(r, 1, word));
			// Core index NUM_CORES is outside the bank
			word = wr_word[r - REG_OTHER];
			bus_write(r, ram_addr(r, NUM_CORES, word), $random(seed), 4'hF);
			bus_read(r, ram_addr(r, NUM_CORES, word), got);
			check_word($sformatf("region %0d out-of-range read", r), got, '0);
			bus_read(r, ram_addr(r, 0, word), got);
			check_word($sformatf("region %0d core 0 after out-of-range write", r), got,
				mirror_word(r, 0, word));
		end

		bus_write(REG_CTRL, ctrl_addr(0), HS_RUN, 4'hF);
		expect_start_after_run();
		bus_read(REG_CTRL, ctrl_addr(1), got);
		check_word("status word while running", got, '0);
		bus_read(REG_CTRL, ctrl_addr(0), got);
		check_word("run word while running", got, HS_RUN);

		exp_start = '1;
		for (int k = 0; k < NUM_CORES; k++) begin
			pulse_core_done(k);
			waited = 0;
			do begin
				@(negedge Bus2IP_Clk);
				waited++;
			end while (core_start[k] && waited < 2);
			exp_start[k] = 1'b0;
			check_word($sformatf("core starts after core %0d done", k), 32'(core_start),
				32'(exp_start));
		end

		bus_read(REG_CTRL, ctrl_addr(0), got);
		check_word("run word after completion", got, '0);
		bus_read(REG_CTRL, ctrl_addr(1), got);
		check_word("status word after completion", got, HS_ALL_DONE);
		check_word("core starts after completion", 32'(core_start), '0);

		// Second run from the completed state
		bus_write(REG_CTRL, ctrl_addr(0), HS_RUN, 4'hF);
		expect_start_after_run();
		bus_read(REG_CTRL, ctrl_addr(1), got);
		check_word("status word after restart", got, '0);

		repeat (2) @(posedge Bus2IP_Clk);
		$display("Checks: %0d, errors: %0d", num_checks, num_errors);
		if (num_errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: hdl/bcrypt_user_logic.sv
// Bus-side user logic of the multi-core bcrypt accelerator
// Handshake block plus per-core other and S-box RAMs on three chip-select regions

module bcrypt_user_logic #(
	parameter int NUM_CORES = 4
) (
	input logic Bus2IP_Clk,
	input logic arst_n_i,
	input logic [bcrypt_pkg::BUS_AW-1:0] bus2ip_addr_i,
	input bcrypt_pkg::region_t bus2ip_cs_i,
	input bcrypt_pkg::bus_word_t bus2ip_data_i,
	input logic [bcrypt_pkg::BUS_DW/8-1:0] bus2ip_be_i,
	input bcrypt_pkg::region_t bus2ip_rdce_i,
	input bcrypt_pkg::region_t bus2ip_wrce_i,
	input logic [NUM_CORES-1:0] core_done_i,
	output bcrypt_pkg::bus_word_t ip2bus_data_o,
	output logic ip2bus_addrack_o,
	output logic ip2bus_rdack_o,
	output logic ip2bus_wrack_o,
	output logic ip2bus_error_o,
	output logic [NUM_CORES-1:0] core_start_o
);
	import bcrypt_pkg::*;

	logic ctrl_we;
	logic ctrl_word;
	bus_word_t ctrl_wdata;
	bus_word_t ctrl_rdata;
	region_t rd_region;
	logic rd_hit;

	core_mem_if #(.NUM_CORES(NUM_CORES), .ADDR_W(OTHER_AW)) mem_other ();
	core_mem_if #(.NUM_CORES(NUM_CORES), .ADDR_W(SBOX_AW)) mem_sbox ();

	bus_addr_decoder #(.NUM_CORES(NUM_CORES)) u_bus_addr_decoder (
		.bus2ip_addr_i (bus2ip_addr_i),
		.bus2ip_cs_i (bus2ip_cs_i),
		.bus2ip_data_i (bus2ip_data_i),
		.bus2ip_be_i (bus2ip_be_i),
		.bus2ip_wrce_i (bus2ip_wrce_i),
		.other_o (mem_other.dec),
		.sbox_o (mem_sbox.dec),
		.ctrl_we_o (ctrl_we),
		.ctrl_word_o (ctrl_word),
		.ctrl_wdata_o (ctrl_wdata),
		.rd_region_o (rd_region),
		.rd_hit_o (rd_hit)
	);

	core_ram_bank #(.NUM_CORES(NUM_CORES), .ADDR_W(OTHER_AW)) u_bank_other (
		.Bus2IP_Clk (Bus2IP_Clk),
		.mem_i (mem_other.bank)
	);

	core_ram_bank #(.NUM_CORES(NUM_CORES), .ADDR_W(SBOX_AW)) u_bank_sbox (
		.Bus2IP_Clk (Bus2IP_Clk),
		.mem_i (mem_sbox.bank)
	);

	core_control #(.NUM_CORES(NUM_CORES)) u_core_control (
		.Bus2IP_Clk (Bus2IP_Clk),
		.arst_n_i (arst_n_i),
		.ctrl_we_i (ctrl_we),
		.ctrl_word_i (ctrl_word),
		.ctrl_wdata_i (ctrl_wdata),
		.core_done_i (core_done_i),
		.core_start_o (core_start_o),
		.ctrl_rdata_o (ctrl_rdata)
	);

	read_return u_read_return (
		.Bus2IP_Clk (Bus2IP_Clk),
		.arst_n_i (arst_n_i),
		.bus2ip_rdce_i (bus2ip_rdce_i),
		.bus2ip_wrce_i (bus2ip_wrce_i),
		.rd_region_i (rd_region),
		.rd_hit_i (rd_hit),
		.ctrl_rdata_i (ctrl_rdata),
		.other_rdata_i (mem_other.rdata),
		.sbox_rdata_i (mem_sbox.rdata),
		.ip2bus_data_o (ip2bus_data_o),
		.ip2bus_rdack_o (ip2bus_rdack_o),
		.ip2bus_wrack_o (ip2bus_wrack_o),
		.ip2bus_addrack_o (ip2bus_addrack_o)
	);

	assign ip2bus_error_o = 1'b0;	// No error responses

endmodule

// File: hdl/read_return.sv
// Bus return path
// Delayed one-cycle read acknowledge, read-data select and gating, write and address acks

module read_return (
	input logic Bus2IP_Clk,
	input logic arst_n_i,
	input bcrypt_pkg::region_t bus2ip_rdce_i,
	input bcrypt_pkg::region_t bus2ip_wrce_i,
	input bcrypt_pkg::region_t rd_region_i,
	input logic rd_hit_i,
	input bcrypt_pkg::bus_word_t ctrl_rdata_i,
	input bcrypt_pkg::bus_word_t other_rdata_i,
	input bcrypt_pkg::bus_word_t sbox_rdata_i,
	output bcrypt_pkg::bus_word_t ip2bus_data_o,
	output logic ip2bus_rdack_o,
	output logic ip2bus_wrack_o,
	output logic ip2bus_addrack_o
);
	import bcrypt_pkg::*;

	logic rd_any;
	logic wr_any;
	logic rd_dly1;
	logic rd_dly2;
	logic rd_ack;
	region_t region_q;
	logic hit_q;
	bus_word_t data_sel;

	assign rd_any = |bus2ip_rdce_i;
	assign wr_any = |bus2ip_wrce_i;

	always_ff @(posedge Bus2IP_Clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			rd_dly1 <= 1'b0;
			rd_dly2 <= 1'b0;
		end else begin
			rd_dly1 <= rd_any;
			rd_dly2 <= rd_dly1;
		end
	end

	// Sampled with the first stage so they line up with the RAM data
	always_ff @(posedge Bus2IP_Clk) begin
		region_q <= rd_region_i;
		hit_q <= rd_hit_i;
	end

	assign rd_ack = rd_dly1 && !rd_dly2;	// Rising edge of RdCE, one cycle late

	always_comb begin
		data_sel = '0;
		if (region_q[REG_CTRL]) begin
			data_sel = ctrl_rdata_i;
		end else if (region_q[REG_OTHER]) begin
			data_sel = other_rdata_i;
		end else if (region_q[REG_SBOX]) begin
			data_sel = sbox_rdata_i;
		end
	end

	assign ip2bus_data_o = (rd_ack && hit_q) ? data_sel : '0;
	assign ip2bus_rdack_o = rd_ack;
	assign ip2bus_wrack_o = wr_any;	// Writes complete in the same cycle
	assign ip2bus_addrack_o = wr_any || (rd_any && rd_ack);

endmodule

// File: hdl/core_control.sv
// Handshake block
// Run and status words, sticky per-core done bits, core start and completion detection

module core_control #(
	parameter int NUM_CORES = 4
) (
	input logic Bus2IP_Clk,
	input logic arst_n_i,
	input logic ctrl_we_i,
	input logic ctrl_word_i,
	input bcrypt_pkg::bus_word_t ctrl_wdata_i,
	input logic [NUM_CORES-1:0] core_done_i,
	output logic [NUM_CORES-1:0] core_start_o,
	output bcrypt_pkg::bus_word_t ctrl_rdata_o
);
	import bcrypt_pkg::*;

	bus_word_t hs_run;	// Word 0
	bus_word_t hs_status;	// Word 1
	bus_word_t rdata_q;
	logic [NUM_CORES-1:0] done_q;
	logic [NUM_CORES-1:0] start_q;
	logic all_done;
	logic run_wr;

	assign all_done = &done_q;
	assign run_wr = ctrl_we_i && !ctrl_word_i;	// Word 1 is read-only

	always_ff @(posedge Bus2IP_Clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			hs_run <= '0;
			hs_status <= '0;
		end else if (all_done) begin
			// Completion wins over a bus write in the same cycle
			hs_run <= '0;
			hs_status <= HS_ALL_DONE;
		end else if (run_wr) begin
			hs_run <= ctrl_wdata_i;
			hs_status <= '0;
		end
	end

	always_ff @(posedge Bus2IP_Clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			done_q <= '0;
		end else if (hs_run == '0) begin
			done_q <= '0;	// Idle clears the sticky bits
		end else begin
			done_q <= done_q | core_done_i;
		end
	end

	always_ff @(posedge Bus2IP_Clk or negedge arst_n_i) begin
		if (!arst_n_i) begin
			start_q <= '0;
		end else begin
			start_q <= (hs_run == HS_RUN) ? ~done_q : '0;
		end
	end

	// Write to word 0 reads back the written value
	always_ff @(posedge Bus2IP_Clk) begin
		if (run_wr) begin
			rdata_q <= ctrl_wdata_i;
		end else begin
			rdata_q <= ctrl_word_i ? hs_status : hs_run;
		end
	end

	assign core_start_o = start_q;
	assign ctrl_rdata_o = rdata_q;

endmodule

// File: hdl/core_ram_bank.sv
// Per-core RAMs of one region
// Bus writes to the strobed core, registered read of the selected core

module core_ram_bank #(
	parameter int NUM_CORES = 4,
	parameter int ADDR_W = 6
) (
	input logic Bus2IP_Clk,
	core_mem_if.bank mem_i
);
	import bcrypt_pkg::*;

	localparam int DEPTH = 2 ** ADDR_W;
	localparam int SEL_W = (NUM_CORES > 1) ? $clog2(NUM_CORES) : 1;

	bus_word_t mem [NUM_CORES][DEPTH];
	bus_word_t rdata_q;
	logic [SEL_W-1:0] rd_core;

	// Decoder keeps core_sel below NUM_CORES
	assign rd_core = mem_i.core_sel[SEL_W-1:0];

	always_ff @(posedge Bus2IP_Clk) begin
		for (int k = 0; k < NUM_CORES; k++) begin
			if (mem_i.we[k]) begin
				mem[k][mem_i.word_addr] <= mem_i.wdata;
			end
		end
	end

	always_ff @(posedge Bus2IP_Clk) begin
		rdata_q <= mem[rd_core][mem_i.word_addr];	// Old data on a same-cycle write
	end

	assign mem_i.rdata = rdata_q;

endmodule

// File: hdl/bus_addr_decoder.sv
// Bus address decoder
// Splits an access into region, core index and word address and builds the write strobes

module bus_addr_decoder #(
	parameter int NUM_CORES = 4
) (
	input logic [bcrypt_pkg::BUS_AW-1:0] bus2ip_addr_i,
	input bcrypt_pkg::region_t bus2ip_cs_i,
	input bcrypt_pkg::bus_word_t bus2ip_data_i,
	input logic [bcrypt_pkg::BUS_DW/8-1:0] bus2ip_be_i,
	input bcrypt_pkg::region_t bus2ip_wrce_i,
	core_mem_if.dec other_o,
	core_mem_if.dec sbox_o,
	output logic ctrl_we_o,
	output logic ctrl_word_o,
	output bcrypt_pkg::bus_word_t ctrl_wdata_o,
	output bcrypt_pkg::region_t rd_region_o,
	output logic rd_hit_o
);
	import bcrypt_pkg::*;

	localparam logic [CORE_SEL_W-1:0] CORE_LIMIT = CORE_SEL_W'(NUM_CORES);

	logic [CORE_SEL_W-1:0] other_idx;
	logic [CORE_SEL_W-1:0] sbox_idx;
	logic other_hit;
	logic sbox_hit;
	logic other_wr;
	logic sbox_wr;

	// Core index sits at a different bit in each region
	assign other_idx = bus2ip_addr_i[OTHER_CORE_LSB +: CORE_SEL_W];
	assign sbox_idx = bus2ip_addr_i[SBOX_CORE_LSB +: CORE_SEL_W];
	assign other_hit = (other_idx < CORE_LIMIT);
	assign sbox_hit = (sbox_idx < CORE_LIMIT);

	// Only byte lane 0 qualifies a write
	assign other_wr = bus2ip_wrce_i[REG_OTHER] && bus2ip_be_i[0] && other_hit;
	assign sbox_wr = bus2ip_wrce_i[REG_SBOX] && bus2ip_be_i[0] && sbox_hit;

	assign other_o.core_sel = other_hit ? other_idx : '0;	// Miss reads core 0, gated later
	assign other_o.word_addr = bus2ip_addr_i[WORD_LSB +: OTHER_AW];
	assign other_o.wdata = bus2ip_data_i;

	assign sbox_o.core_sel = sbox_hit ? sbox_idx : '0;
	assign sbox_o.word_addr = bus2ip_addr_i[WORD_LSB +: SBOX_AW];
	assign sbox_o.wdata = bus2ip_data_i;

	always_comb begin
		other_o.we = '0;
		sbox_o.we = '0;
		for (int k = 0; k < NUM_CORES; k++) begin
			other_o.we[k] = other_wr && (other_idx == CORE_SEL_W'(k));
			sbox_o.we[k] = sbox_wr && (sbox_idx == CORE_SEL_W'(k));
		end
	end

	// Handshake block
	assign ctrl_we_o = bus2ip_wrce_i[REG_CTRL] && bus2ip_be_i[0];
	assign ctrl_word_o = bus2ip_addr_i[WORD_LSB];
	assign ctrl_wdata_o = bus2ip_data_i;

	assign rd_region_o = bus2ip_cs_i;
	assign rd_hit_o = bus2ip_cs_i[REG_CTRL]
		|| (bus2ip_cs_i[REG_OTHER] && other_hit)
		|| (bus2ip_cs_i[REG_SBOX] && sbox_hit);

endmodule

// File: hdl/core_mem_if.sv
// Bus-side port of one region's per-core RAMs
// Write strobe is one bit per core, read data follows the address by one clock

interface core_mem_if #(
	parameter int NUM_CORES = 4,
	parameter int ADDR_W = 6
);
	import bcrypt_pkg::*;

	logic [CORE_SEL_W-1:0] core_sel;	// Already range-checked by the decoder
	logic [ADDR_W-1:0] word_addr;
	bus_word_t wdata;
	logic [NUM_CORES-1:0] we;	// One-cycle strobe, only the indexed core
	bus_word_t rdata;

	modport dec (
		output core_sel,
		output word_addr,
		output wdata,
		output we
	);

	modport bank (
		input core_sel,
		input word_addr,
		input wdata,
		input we,
		output rdata
	);

endinterface

// File: hdl/bcrypt_pkg.sv
// Shared widths, address fields and handshake codes for the
// bcrypt accelerator bus-side logic

package bcrypt_pkg;

	// Bus widths
	localparam int BUS_AW = 32;
	localparam int BUS_DW = 32;

	// Chip-select regions
	localparam int NUM_REGIONS = 3;
	localparam int REG_CTRL = 0;	// Handshake block
	localparam int REG_OTHER = 1;	// Per-core 64-word RAMs
	localparam int REG_SBOX = 2;	// Per-core S-box RAMs

	// Address fields inside the bus address
	localparam int CORE_SEL_W = 7;
	localparam int OTHER_AW = 6;
	localparam int SBOX_AW = 10;
	localparam int OTHER_CORE_LSB = 8;
	localparam int SBOX_CORE_LSB = 12;
	localparam int WORD_LSB = 2;

	typedef logic [BUS_DW-1:0] bus_word_t;
	typedef logic [NUM_REGIONS-1:0] region_t;

	// Handshake codes
	localparam bus_word_t HS_RUN = 32'd1;	// Word 0 value that starts the cores
	localparam bus_word_t HS_ALL_DONE = 32'hFF;	// Word 1 after every core finished

endpackage
